//--- verif/ex_mem_patterns.txt
// rs1 rs2 csrr imm pc src1 src2 wcut aluop rd csr gwen cwen mren mwen memop csel csrop
// then expected gpr_wdata, expected csr_wdata, stall flag (0 none, 1 random, 2 hold)
5 7 0 0 0 0 0 0 0 1 123 1 0 0 0 0 0 0 c 0 0
3 5 0 0 0 0 0 0 1 2 0 1 0 0 0 0 0 0 fffffffffffffffe 0 0
1 3f 0 0 0 0 0 0 2 3 0 1 0 0 0 0 0 0 8000000000000000 0 0
ffffffffffffffff 1 0 0 0 0 0 0 3 4 0 1 0 0 0 0 0 0 1 0 0
ffffffffffffffff 1 0 0 0 0 0 0 4 5 0 1 0 0 0 0 0 0 0 0 0
f0f0 ff00 0 0 0 0 0 0 5 6 0 1 0 0 0 0 0 0 ff0 0 1
8000000000000000 4 0 0 0 0 0 0 6 7 0 1 0 0 0 0 0 0 0800000000000000 0 1
8000000000000000 4 0 0 0 0 0 0 7 8 0 1 0 0 0 0 0 0 f800000000000000 0 1
10 0 0 1 0 0 1 0 8 9 0 1 0 0 0 0 0 0 11 0 2
ff f 0 0 0 0 0 0 9 a 0 1 0 0 0 0 0 0 f 0 1
0 0 0 ffffffff80000000 0 0 1 0 a b 0 1 0 0 0 0 0 0 ffffffff80000000 0 0
0 0 0 0 1000 1 2 0 0 c 0 1 0 0 0 0 0 0 1004 0 0
7fffffff 1 0 0 0 0 0 1 0 d 0 1 0 0 0 0 0 0 ffffffff80000000 0 0
1 3f 0 0 0 0 0 1 2 e 0 1 0 0 0 0 0 0 ffffffff80000000 0 0
80000000 4 0 0 0 0 0 1 7 f 0 1 0 0 0 0 0 0 fffffffff8000000 0 0
1234 0 ff00 0 0 0 0 0 0 10 300 1 1 0 0 0 1 1 ff00 1234 0
f 0 ff00 0 0 0 0 0 0 11 341 1 1 0 0 0 1 2 ff00 ff0f 0
ff 0 f 8 0 0 0 0 0 12 344 1 1 0 0 0 1 7 f 7 1
100 8877665544332211 0 0 0 0 1 0 0 5 0 0 0 0 1 3 0 0 100 0 0
100 a5 0 9 0 0 1 0 0 5 0 0 0 0 1 0 0 0 109 0 0
100 beef 0 c 0 0 1 0 0 5 0 0 0 0 1 1 0 0 10c 0 0
100 0 0 0 0 0 1 0 0 16 0 1 0 1 0 3 0 0 8877665544332211 0 1
100 0 0 9 0 0 1 0 0 17 0 1 0 1 0 0 0 0 ffffffffffffffa5 0 1
100 0 0 9 0 0 1 0 0 18 0 1 0 1 0 4 0 0 a5 0 1
100 0 0 c 0 0 1 0 0 19 0 1 0 1 0 5 0 0 beef 0 1
100 0 0 c 0 0 1 0 0 1a 0 1 0 1 0 1 0 0 ffffffffffffbeef 0 1
100 0 0 4 0 0 1 0 0 1b 0 1 0 1 0 2 0 0 ffffffff88776655 0 2
100 0 0 4 0 0 1 0 0 1c 0 1 0 1 0 6 0 0 88776655 0 1
100 0 0 6 0 0 1 0 0 1d 0 1 0 1 0 0 0 0 77 0 0

//--- filelist.f
verilog/ex_pkg.sv
verilog/exec_unit.sv
verilog/store_align.sv
verilog/ex_stage.sv
verilog/mem_stage.sv
verilog/data_sram.sv
verilog/core_ex_mem_top.sv
verif/tb_core_ex_mem.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module core_ex_mem_top

sim:
	verilator --binary --timing -f filelist.f --top-module tb_core_ex_mem -Mdir obj_dir
	./obj_dir/Vtb_core_ex_mem | tee sim.log
	grep -q "^>>> PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/tb_core_ex_mem.sv
// drives rows of verif/ex_mem_patterns.txt from the project root; row count fixed by N_ROWS
`timescale 1ns/100ps

module tb_core_ex_mem;

  localparam int N_ROWS     = 29;
  localparam int N_COLS     = 21;
  localparam int MAX_CYCLES = 4 * N_ROWS + 50;

  logic                           i_clk;
  logic                           i_rst_n;
  logic                           i_ds_to_es_valid;
  ex_pkg::ds_to_es_t              i_ds_to_es_bus;
  logic                           i_ws_allowin;
  logic                           o_es_allowin;
  logic                           o_ms_to_ws_valid;
  ex_pkg::ms_to_ws_t              o_ms_to_ws_bus;
  logic [ex_pkg::GPR_ADDR_WD-1:0] o_es_rd;
  logic [ex_pkg::CSR_ADDR_WD-1:0] o_es_csr_rd;
  logic [ex_pkg::GPR_ADDR_WD-1:0] o_ms_rd;
  logic [ex_pkg::CSR_ADDR_WD-1:0] o_ms_csr_rd;

  logic [63:0]       pat [N_ROWS*N_COLS];
  ex_pkg::ms_to_ws_t exp_q [$];
  int                acc_q [$];
  int                row_q [$];
  int                bundle_errs;
  int                hazard_errs;
  int                flow_errs;

  core_ex_mem_top #(
    .SRAM_ADDR_WD    (32),
    .SRAM_DEPTH_LOG2 (10)
  ) dut_i (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_ds_to_es_valid (i_ds_to_es_valid),
    .i_ds_to_es_bus   (i_ds_to_es_bus),
    .o_es_allowin     (o_es_allowin),
    .o_ms_to_ws_valid (o_ms_to_ws_valid),
    .o_ms_to_ws_bus   (o_ms_to_ws_bus),
    .i_ws_allowin     (i_ws_allowin),
    .o_es_rd          (o_es_rd),
    .o_es_csr_rd      (o_es_csr_rd),
    .o_ms_rd          (o_ms_rd),
    .o_ms_csr_rd      (o_ms_csr_rd)
  );

  always #10 i_clk = ~i_clk;

  function automatic logic [63:0] field(int row, int c);
    return pat[row*N_COLS + c];
  endfunction

  function automatic ex_pkg::ds_to_es_t make_bundle(int row);
    ex_pkg::ds_to_es_t b;
    logic [63:0]       w [N_COLS];
    for (int c = 0; c < N_COLS; c++)
      w[c] = field(row, c);
    b.rs1data      = w[0];
    b.rs2data      = w[1];
    b.csrrdata     = w[2];
    b.imm          = w[3];
    b.pc           = w[4];
    b.alu_src1_sel = ex_pkg::src1_sel_e'(w[5][0]);
    b.alu_src2_sel = ex_pkg::src2_sel_e'(w[6][1:0]);
    b.alu_word_cut = w[7][0];
    b.alu_op       = ex_pkg::alu_op_e'(w[8][4:0]);
    b.rd           = w[9][4:0];
    b.csr          = w[10][11:0];
    b.gpr_wen      = w[11][0];
    b.csr_wen      = w[12][0];
    b.mem_ren      = w[13][0];
    b.mem_wen      = w[14][0];
    b.mem_op       = ex_pkg::mem_op_e'(w[15][2:0]);
    b.csr_inst_sel = w[16][0];
    b.csr_op       = ex_pkg::csr_op_e'(w[17][2:0]);
    return b;
  endfunction

  // register fields pass straight through, data words come from the file
  function automatic ex_pkg::ms_to_ws_t make_expect(int row);
    ex_pkg::ms_to_ws_t e;
    ex_pkg::ds_to_es_t b;
    b           = make_bundle(row);
    e.rd        = b.rd;
    e.csr       = b.csr;
    e.gpr_wen   = b.gpr_wen;
    e.csr_wen   = b.csr_wen;
    e.gpr_wdata = field(row, 18);
    e.csr_wdata = field(row, 19);
    return e;
  endfunction

  function automatic logic [ex_pkg::GPR_ADDR_WD-1:0] hazard_rd(logic valid, int row);
    ex_pkg::ds_to_es_t b;
    b = make_bundle(row);
    return (valid && b.gpr_wen) ? b.rd : '0;
  endfunction

  function automatic logic [ex_pkg::CSR_ADDR_WD-1:0] hazard_csr(logic valid, int row);
    ex_pkg::ds_to_es_t b;
    b = make_bundle(row);
    return (valid && b.csr_wen) ? b.csr : '0;
  endfunction

  task automatic check_ws_bundle(input ex_pkg::ms_to_ws_t got, input ex_pkg::ms_to_ws_t exp);
    if (got !== exp) begin
      bundle_errs++;
      $display("ERROR %0t: wb rd/csr/wen gpr csr_w %h/%h/%b%b %h %h, expected %h/%h/%b%b %h %h",
               $time, got.rd, got.csr, got.gpr_wen, got.csr_wen, got.gpr_wdata, got.csr_wdata,
               exp.rd, exp.csr, exp.gpr_wen, exp.csr_wen, exp.gpr_wdata, exp.csr_wdata);
    end
  endtask

  task automatic check_hazard(input string stage,
                              input logic [ex_pkg::GPR_ADDR_WD-1:0] got_rd,
                              input logic [ex_pkg::GPR_ADDR_WD-1:0] exp_rd,
                              input logic [ex_pkg::CSR_ADDR_WD-1:0] got_csr,
                              input logic [ex_pkg::CSR_ADDR_WD-1:0] exp_csr);
    if (got_rd !== exp_rd || got_csr !== exp_csr) begin
      hazard_errs++;
      $display("ERROR %0t: %s hazard rd %h csr %h, expected rd %h csr %h",
               $time, stage, got_rd, got_csr, exp_rd, exp_csr);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      flow_errs++;
      $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  initial begin
    int   cycle;
    int   next_row;
    int   last_low;
    int   held;
    int   full_seen;
    int   es_row;
    int   ms_row;
    logic es_v;
    logic ms_v;
    logic ms_allow;
    logic es_allow;
    logic timed_out;

    void'($urandom(32'hdf9a));
    i_clk            = 1'b0;
    i_rst_n          = 1'b0;
    i_ds_to_es_valid = 1'b0;
    i_ds_to_es_bus   = '0;
    i_ws_allowin     = 1'b1;
    bundle_errs = 0;
    hazard_errs = 0;
    flow_errs   = 0;
    cycle     = 0;
    next_row  = 0;
    last_low  = -1;
    held      = 0;
    full_seen = 0;
    es_row    = 0;
    ms_row    = 0;
    es_v      = 1'b0;
    ms_v      = 1'b0;
    $readmemh("verif/ex_mem_patterns.txt", pat);

    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;

    while ((next_row < N_ROWS || exp_q.size() != 0) && cycle < MAX_CYCLES) begin
      @(negedge i_clk);
      cycle++;
      // ws_allowin here still holds last cycle's value
      check_flag("o_ms_to_ws_valid", o_ms_to_ws_valid, ms_v);
      check_flag("o_es_allowin", o_es_allowin, !es_v || !ms_v || i_ws_allowin);
      check_hazard("ex", o_es_rd, hazard_rd(es_v, es_row), o_es_csr_rd, hazard_csr(es_v, es_row));
      check_hazard("mem", o_ms_rd, hazard_rd(ms_v, ms_row), o_ms_csr_rd, hazard_csr(ms_v, ms_row));
      if (!o_es_allowin)
        full_seen++;

      // stall flag 1 random, 2 holds low for three cycles
      i_ws_allowin = 1'b1;
      if (ms_v && field(row_q[0], 20) == 64'd2 && held < 3) begin
        i_ws_allowin = 1'b0;
        held++;
      end else if (ms_v && field(row_q[0], 20) != 64'd0) begin
        i_ws_allowin = 1'($urandom % 2);
      end
      if (!i_ws_allowin)
        last_low = cycle;

      if (o_ms_to_ws_valid && i_ws_allowin && exp_q.size() != 0) begin
        check_ws_bundle(o_ms_to_ws_bus, exp_q[0]);
        if (last_low < acc_q[0] && cycle - acc_q[0] != 2) begin
          flow_errs++;
          $display("ERROR %0t: result took %0d cycles without stall, expected 2",
                   $time, cycle - acc_q[0]);
        end
        void'(exp_q.pop_front());
        void'(acc_q.pop_front());
        void'(row_q.pop_front());
        held = 0;
      end

      ms_allow = !ms_v || i_ws_allowin;
      es_allow = !es_v || ms_allow;
      i_ds_to_es_valid = (next_row < N_ROWS);
      if (next_row < N_ROWS)
        i_ds_to_es_bus = make_bundle(next_row);
      if (ms_allow) begin
        ms_v   = es_v;
        ms_row = es_row;
      end
      if (es_allow) begin
        es_v   = i_ds_to_es_valid;
        es_row = next_row;
        if (i_ds_to_es_valid) begin
          exp_q.push_back(make_expect(next_row));
          acc_q.push_back(cycle);
          row_q.push_back(next_row);
          next_row++;
        end
      end
    end

    timed_out = (next_row < N_ROWS || exp_q.size() != 0);
    if (full_seen == 0) begin
      flow_errs++;
      $display("back-pressure never filled both stages, o_es_allowin stayed high");
    end
    if (timed_out)
      $display("timeout after %0d cycles, %0d rows not issued, %0d results outstanding",
               cycle, N_ROWS - next_row, exp_q.size());
    $display("errors: bundle %0d hazard %0d flow %0d", bundle_errs, hazard_errs, flow_errs);
    if (!timed_out && bundle_errs == 0 && hazard_errs == 0 && flow_errs == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- verilog/core_ex_mem_top.sv
// execute and memory slice; decode and writeback sit outside, RAM is private to the slice
`timescale 1ns/100ps

module core_ex_mem_top #(
  parameter int SRAM_ADDR_WD    = 32,
  parameter int SRAM_DEPTH_LOG2 = 10
) (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_ds_to_es_valid,
  input  ex_pkg::ds_to_es_t              i_ds_to_es_bus,
  output logic                           o_es_allowin,
  output logic                           o_ms_to_ws_valid,
  output ex_pkg::ms_to_ws_t              o_ms_to_ws_bus,
  input  logic                           i_ws_allowin,
  output logic [ex_pkg::GPR_ADDR_WD-1:0] o_es_rd,
  output logic [ex_pkg::CSR_ADDR_WD-1:0] o_es_csr_rd,
  output logic [ex_pkg::GPR_ADDR_WD-1:0] o_ms_rd,
  output logic [ex_pkg::CSR_ADDR_WD-1:0] o_ms_csr_rd
);

  logic                    es_to_ms_valid;
  ex_pkg::es_to_ms_t       es_to_ms_bus;
  logic                    ms_allowin;
  logic [SRAM_ADDR_WD-1:0] sram_addr;
  logic                    sram_ren;
  logic                    sram_wen;
  logic [7:0]              sram_wmask;
  logic [ex_pkg::XLEN-1:0] sram_wdata;
  logic [ex_pkg::XLEN-1:0] sram_rdata;

  ex_stage #(
    .SRAM_ADDR_WD (SRAM_ADDR_WD)
  ) u_ex_stage (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_ms_allowin     (ms_allowin),
    .o_es_allowin     (o_es_allowin),
    .i_ds_to_es_valid (i_ds_to_es_valid),
    .i_ds_to_es_bus   (i_ds_to_es_bus),
    .o_es_to_ms_valid (es_to_ms_valid),
    .o_es_to_ms_bus   (es_to_ms_bus),
    .o_sram_addr      (sram_addr),
    .o_sram_ren       (sram_ren),
    .o_sram_wen       (sram_wen),
    .o_sram_wmask     (sram_wmask),
    .o_sram_wdata     (sram_wdata),
    .o_es_rd          (o_es_rd),
    .o_es_csr_rd      (o_es_csr_rd)
  );

  mem_stage u_mem_stage (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_ws_allowin     (i_ws_allowin),
    .o_ms_allowin     (ms_allowin),
    .i_es_to_ms_valid (es_to_ms_valid),
    .i_es_to_ms_bus   (es_to_ms_bus),
    .i_sram_rdata     (sram_rdata),
    .o_ms_to_ws_valid (o_ms_to_ws_valid),
    .o_ms_to_ws_bus   (o_ms_to_ws_bus),
    .o_ms_rd          (o_ms_rd),
    .o_ms_csr_rd      (o_ms_csr_rd)
  );

  data_sram #(
    .SRAM_ADDR_WD    (SRAM_ADDR_WD),
    .SRAM_DEPTH_LOG2 (SRAM_DEPTH_LOG2)
  ) u_data_sram (
    .i_clk   (i_clk),
    .i_addr  (sram_addr),
    .i_ren   (sram_ren),
    .i_wen   (sram_wen),
    .i_wmask (sram_wmask),
    .i_wdata (sram_wdata),
    .o_rdata (sram_rdata)
  );

endmodule

//--- verilog/data_sram.sv
// doubleword RAM, needs SRAM_ADDR_WD >= SRAM_DEPTH_LOG2+3; upper address bits wrap, no reset
`timescale 1ns/100ps

module data_sram #(
  parameter int SRAM_ADDR_WD    = 32,
  parameter int SRAM_DEPTH_LOG2 = 10
) (
  input  logic                    i_clk,
  input  logic [SRAM_ADDR_WD-1:0] i_addr,
  input  logic                    i_ren,
  input  logic                    i_wen,
  input  logic [7:0]              i_wmask,
  input  logic [ex_pkg::XLEN-1:0] i_wdata,
  output logic [ex_pkg::XLEN-1:0] o_rdata
);

  logic [ex_pkg::XLEN-1:0]    mem [2**SRAM_DEPTH_LOG2];
  logic [SRAM_DEPTH_LOG2-1:0] index;

  assign index = i_addr[SRAM_DEPTH_LOG2+2:3];  // doubleword index

  always_ff @(posedge i_clk) begin
    if (i_wen) begin
      for (int b = 0; b < 8; b++) begin
        if (i_wmask[b])
          mem[index][b*8 +: 8] <= i_wdata[b*8 +: 8];
      end
    end
  end

  // rdata holds between reads
  always_ff @(posedge i_clk) begin
    if (i_ren)
      o_rdata <= mem[index];
  end

endmodule

//--- verilog/mem_stage.sv
// memory stage; expects RAM read data the edge after the ex request, held while stalled
`timescale 1ns/100ps

module mem_stage (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_ws_allowin,
  output logic                           o_ms_allowin,
  input  logic                           i_es_to_ms_valid,
  input  ex_pkg::es_to_ms_t              i_es_to_ms_bus,
  input  logic [ex_pkg::XLEN-1:0]        i_sram_rdata,
  output logic                           o_ms_to_ws_valid,
  output ex_pkg::ms_to_ws_t              o_ms_to_ws_bus,
  output logic [ex_pkg::GPR_ADDR_WD-1:0] o_ms_rd,
  output logic [ex_pkg::CSR_ADDR_WD-1:0] o_ms_csr_rd
);

  logic                    ms_valid;
  ex_pkg::es_to_ms_t       ms_bus;
  logic [ex_pkg::XLEN-1:0] rdata_shift;
  logic [ex_pkg::XLEN-1:0] load_data;

  assign o_ms_allowin     = !ms_valid || i_ws_allowin;
  assign o_ms_to_ws_valid = ms_valid;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n)
      ms_valid <= 1'b0;
    else if (o_ms_allowin)
      ms_valid <= i_es_to_ms_valid;
  end

  always_ff @(posedge i_clk) begin
    if (i_es_to_ms_valid && o_ms_allowin)
      ms_bus <= i_es_to_ms_bus;
  end

  // move the addressed byte down to lane 0
  assign rdata_shift = i_sram_rdata >> {ms_bus.alu_result[2:0], 3'b000};

  always_comb begin
    case (ms_bus.mem_op)
      ex_pkg::MEM_B:  load_data = {{56{rdata_shift[7]}}, rdata_shift[7:0]};
      ex_pkg::MEM_H:  load_data = {{48{rdata_shift[15]}}, rdata_shift[15:0]};
      ex_pkg::MEM_W:  load_data = {{32{rdata_shift[31]}}, rdata_shift[31:0]};
      ex_pkg::MEM_BU: load_data = {56'b0, rdata_shift[7:0]};
      ex_pkg::MEM_HU: load_data = {48'b0, rdata_shift[15:0]};
      ex_pkg::MEM_WU: load_data = {32'b0, rdata_shift[31:0]};
      default:        load_data = rdata_shift;  // doubleword
    endcase
  end

  always_comb begin
    o_ms_to_ws_bus.rd        = ms_bus.rd;
    o_ms_to_ws_bus.csr       = ms_bus.csr;
    o_ms_to_ws_bus.gpr_wen   = ms_bus.gpr_wen;
    o_ms_to_ws_bus.csr_wen   = ms_bus.csr_wen;
    o_ms_to_ws_bus.csr_wdata = ms_bus.csr_result;
    if (ms_bus.mem_ren)
      o_ms_to_ws_bus.gpr_wdata = load_data;
    else if (ms_bus.csr_inst_sel)
      o_ms_to_ws_bus.gpr_wdata = ms_bus.csrrdata;  // old csr value
    else
      o_ms_to_ws_bus.gpr_wdata = ms_bus.alu_result;
  end

  assign o_ms_rd     = (ms_valid && ms_bus.gpr_wen) ? ms_bus.rd : '0;
  assign o_ms_csr_rd = (ms_valid && ms_bus.csr_wen) ? ms_bus.csr : '0;

endmodule

//--- verilog/ex_stage.sv
// execute stage, always one cycle; RAM address is the ALU result cut to SRAM_ADDR_WD (<= 64)
`timescale 1ns/100ps

module ex_stage #(
  parameter int SRAM_ADDR_WD = 32
) (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_ms_allowin,
  output logic                           o_es_allowin,
  input  logic                           i_ds_to_es_valid,
  input  ex_pkg::ds_to_es_t              i_ds_to_es_bus,
  output logic                           o_es_to_ms_valid,
  output ex_pkg::es_to_ms_t              o_es_to_ms_bus,
  output logic [SRAM_ADDR_WD-1:0]        o_sram_addr,
  output logic                           o_sram_ren,
  output logic                           o_sram_wen,
  output logic [7:0]                     o_sram_wmask,
  output logic [ex_pkg::XLEN-1:0]        o_sram_wdata,
  output logic [ex_pkg::GPR_ADDR_WD-1:0] o_es_rd,
  output logic [ex_pkg::CSR_ADDR_WD-1:0] o_es_csr_rd
);

  logic                    es_valid;
  ex_pkg::ds_to_es_t       es_bus;
  logic [ex_pkg::XLEN-1:0] alu_result;
  logic [ex_pkg::XLEN-1:0] csr_result;
  logic                    es_go;  // handing the item to mem this cycle

  assign o_es_allowin     = !es_valid || i_ms_allowin;
  assign o_es_to_ms_valid = es_valid;
  assign es_go            = es_valid && i_ms_allowin;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n)
      es_valid <= 1'b0;
    else if (o_es_allowin)
      es_valid <= i_ds_to_es_valid;
  end

  always_ff @(posedge i_clk) begin
    if (i_ds_to_es_valid && o_es_allowin)
      es_bus <= i_ds_to_es_bus;
  end

  exec_unit u_exec_unit (
    .i_bundle     (es_bus),
    .o_alu_result (alu_result),
    .o_csr_result (csr_result)
  );

  store_align u_store_align (
    .i_mem_op  (es_bus.mem_op),
    .i_addr_lo (alu_result[2:0]),
    .i_rs2data (es_bus.rs2data),
    .o_wmask   (o_sram_wmask),
    .o_wdata   (o_sram_wdata)
  );

  // request only on the transfer edge so a stall never repeats it
  assign o_sram_addr = alu_result[SRAM_ADDR_WD-1:0];  // rs1 + imm
  assign o_sram_ren  = es_go && es_bus.mem_ren;
  assign o_sram_wen  = es_go && es_bus.mem_wen;

  assign o_es_rd     = (es_valid && es_bus.gpr_wen) ? es_bus.rd : '0;
  assign o_es_csr_rd = (es_valid && es_bus.csr_wen) ? es_bus.csr : '0;

  always_comb begin
    o_es_to_ms_bus.rd           = es_bus.rd;
    o_es_to_ms_bus.csr          = es_bus.csr;
    o_es_to_ms_bus.gpr_wen      = es_bus.gpr_wen;
    o_es_to_ms_bus.csr_wen      = es_bus.csr_wen;
    o_es_to_ms_bus.mem_ren      = es_bus.mem_ren;
    o_es_to_ms_bus.mem_op       = es_bus.mem_op;
    o_es_to_ms_bus.csr_inst_sel = es_bus.csr_inst_sel;
    o_es_to_ms_bus.csrrdata     = es_bus.csrrdata;
    o_es_to_ms_bus.alu_result   = alu_result;
    o_es_to_ms_bus.csr_result   = csr_result;
  end

endmodule

//--- verilog/store_align.sv
// store lane placement for a 64-bit data RAM; misaligned stores are not detected
`timescale 1ns/100ps

module store_align (
  input  ex_pkg::mem_op_e         i_mem_op,
  input  logic [2:0]              i_addr_lo,
  input  logic [ex_pkg::XLEN-1:0] i_rs2data,
  output logic [7:0]              o_wmask,
  output logic [ex_pkg::XLEN-1:0] o_wdata
);

  // data is replicated over every lane, the mask picks the live bytes
  always_comb begin
    case (i_mem_op)
      ex_pkg::MEM_B, ex_pkg::MEM_BU: begin
        o_wdata = {8{i_rs2data[7:0]}};
        o_wmask = 8'b0000_0001 << i_addr_lo;
      end
      ex_pkg::MEM_H, ex_pkg::MEM_HU: begin
        o_wdata = {4{i_rs2data[15:0]}};
        o_wmask = 8'b0000_0011 << {i_addr_lo[2:1], 1'b0};
      end
      ex_pkg::MEM_W, ex_pkg::MEM_WU: begin
        o_wdata = {2{i_rs2data[31:0]}};
        o_wmask = 8'b0000_1111 << {i_addr_lo[2], 2'b00};
      end
      default: begin  // doubleword
        o_wdata = i_rs2data;
        o_wmask = 8'hff;
      end
    endcase
  end

endmodule

//--- verilog/exec_unit.sv
// combinational ALU and CSR value; word cut follows RV64 *W rules, no overflow or trap checks
`timescale 1ns/100ps

module exec_unit (
  input  ex_pkg::ds_to_es_t       i_bundle,
  output logic [ex_pkg::XLEN-1:0] o_alu_result,
  output logic [ex_pkg::XLEN-1:0] o_csr_result
);

  logic [ex_pkg::XLEN-1:0] src1;
  logic [ex_pkg::XLEN-1:0] src2;
  logic [ex_pkg::XLEN-1:0] shift_src;
  logic [5:0]              shamt;
  logic [ex_pkg::XLEN-1:0] result_full;
  logic [ex_pkg::XLEN-1:0] csr_operand;

  // operand select
  always_comb begin
    src1 = (i_bundle.alu_src1_sel == ex_pkg::SRC1_PC) ? i_bundle.pc : i_bundle.rs1data;
    case (i_bundle.alu_src2_sel)
      ex_pkg::SRC2_IMM:  src2 = i_bundle.imm;
      ex_pkg::SRC2_FOUR: src2 = 64'd4;
      default:           src2 = i_bundle.rs2data;
    endcase
  end

  // word shifts only see the low 32 bits of src1
  always_comb begin
    if (i_bundle.alu_word_cut) begin
      shamt = {1'b0, src2[4:0]};
      if (i_bundle.alu_op == ex_pkg::ALU_SRA)
        shift_src = {{32{src1[31]}}, src1[31:0]};
      else
        shift_src = {32'b0, src1[31:0]};
    end else begin
      shamt     = src2[5:0];
      shift_src = src1;
    end
  end

  always_comb begin
    case (i_bundle.alu_op)
      ex_pkg::ALU_ADD:  result_full = src1 + src2;
      ex_pkg::ALU_SUB:  result_full = src1 - src2;
      ex_pkg::ALU_SLL:  result_full = shift_src << shamt;
      ex_pkg::ALU_SLT:  result_full = {63'b0, $signed(src1) < $signed(src2)};
      ex_pkg::ALU_SLTU: result_full = {63'b0, src1 < src2};
      ex_pkg::ALU_XOR:  result_full = src1 ^ src2;
      ex_pkg::ALU_SRL:  result_full = shift_src >> shamt;
      ex_pkg::ALU_SRA:  result_full = $unsigned($signed(shift_src) >>> shamt);
      ex_pkg::ALU_OR:   result_full = src1 | src2;
      ex_pkg::ALU_AND:  result_full = src1 & src2;
      ex_pkg::ALU_LUI:  result_full = src2;
      default:          result_full = '0;
    endcase
  end

  assign o_alu_result = i_bundle.alu_word_cut ?
                        {{32{result_full[31]}}, result_full[31:0]} : result_full;

  // immediate forms carry the zimm in imm
  always_comb begin
    case (i_bundle.csr_op)
      ex_pkg::CSR_RWI, ex_pkg::CSR_RSI, ex_pkg::CSR_RCI: csr_operand = i_bundle.imm;
      default:                                           csr_operand = i_bundle.rs1data;
    endcase
  end

  always_comb begin
    case (i_bundle.csr_op)
      ex_pkg::CSR_RW, ex_pkg::CSR_RWI: o_csr_result = csr_operand;
      ex_pkg::CSR_RS, ex_pkg::CSR_RSI: o_csr_result = i_bundle.csrrdata | csr_operand;
      ex_pkg::CSR_RC, ex_pkg::CSR_RCI: o_csr_result = i_bundle.csrrdata & ~csr_operand;
      default:                         o_csr_result = i_bundle.csrrdata;  // unchanged
    endcase
  end

endmodule

//--- verilog/ex_pkg.sv
// shared widths, opcode encodings and stage bundles; XLEN is fixed at 64, RV64 only
package ex_pkg;

  localparam int XLEN        = 64;
  localparam int GPR_ADDR_WD = 5;
  localparam int CSR_ADDR_WD = 12;

  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_SLL  = 5'd2,
    ALU_SLT  = 5'd3,
    ALU_SLTU = 5'd4,
    ALU_XOR  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_OR   = 5'd8,
    ALU_AND  = 5'd9,
    ALU_LUI  = 5'd10  // passes operand 2 through
  } alu_op_e;

  typedef enum logic {
    SRC1_RS1 = 1'b0,
    SRC1_PC  = 1'b1
  } src1_sel_e;

  typedef enum logic [1:0] {
    SRC2_RS2  = 2'd0,
    SRC2_IMM  = 2'd1,
    SRC2_FOUR = 2'd2  // link address
  } src2_sel_e;

  typedef enum logic [2:0] {
    CSR_NONE = 3'd0,
    CSR_RW   = 3'd1,
    CSR_RS   = 3'd2,
    CSR_RC   = 3'd3,
    CSR_RWI  = 3'd5,
    CSR_RSI  = 3'd6,
    CSR_RCI  = 3'd7
  } csr_op_e;

  typedef enum logic [2:0] {
    MEM_B  = 3'd0,
    MEM_H  = 3'd1,
    MEM_W  = 3'd2,
    MEM_D  = 3'd3,
    MEM_BU = 3'd4,
    MEM_HU = 3'd5,
    MEM_WU = 3'd6
  } mem_op_e;

  typedef struct packed {
    logic [XLEN-1:0]        rs1data;
    logic [XLEN-1:0]        rs2data;
    logic [XLEN-1:0]        csrrdata;
    logic [XLEN-1:0]        imm;
    logic [XLEN-1:0]        pc;
    src1_sel_e              alu_src1_sel;
    src2_sel_e              alu_src2_sel;
    logic                   alu_word_cut;
    alu_op_e                alu_op;
    logic [GPR_ADDR_WD-1:0] rd;
    logic [CSR_ADDR_WD-1:0] csr;
    logic                   gpr_wen;
    logic                   csr_wen;
    logic                   mem_ren;
    logic                   mem_wen;
    mem_op_e                mem_op;
    logic                   csr_inst_sel;  // csrrdata goes to the gpr
    csr_op_e                csr_op;
  } ds_to_es_t;

  typedef struct packed {
    logic [GPR_ADDR_WD-1:0] rd;
    logic [CSR_ADDR_WD-1:0] csr;
    logic                   gpr_wen;
    logic                   csr_wen;
    logic                   mem_ren;
    mem_op_e                mem_op;
    logic                   csr_inst_sel;
    logic [XLEN-1:0]        csrrdata;
    logic [XLEN-1:0]        alu_result;  // also the load address
    logic [XLEN-1:0]        csr_result;
  } es_to_ms_t;

  typedef struct packed {
    logic [GPR_ADDR_WD-1:0] rd;
    logic [CSR_ADDR_WD-1:0] csr;
    logic                   gpr_wen;
    logic                   csr_wen;
    logic [XLEN-1:0]        gpr_wdata;
    logic [XLEN-1:0]        csr_wdata;
  } ms_to_ws_t;

endpackage
